// ==== source/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

`define REG_ID_W    7           // Register id width
`define GPR_COUNT   32
`define GPR_IDX_W   5           // Array index bits below the special id flag
`define DATA_W      64
`define HALF_W      32          // Multiply operand and product half
`define INSTR_W     32
`define IMM_W       33          // Immediate with sign bit on top
`define IMM_FLD_W   10
`define PC_W        32
`define PC_STEP     32'd4
`define OP_W        4

// Instruction fields
`define FLD_OP      31:28
`define FLD_RN      27:22
`define FLD_RS      21:16
`define FLD_RT      15:10
`define FLD_IMM     9:0

// Special register ids
`define GR_DLR      7'd32
`define GR_DHR      7'd33
`define GR_SP       7'd34
`define GR_PC       7'd35
`define GR_IMM      7'd62
`define GR_ZZR      7'd63

`endif

// ==== source/corePkg.sv ====
`include "core_macros.svh"

package corePkg;

	// Ids below 32 select the array and bit 5 marks a special id
	typedef logic [`REG_ID_W-1:0] regId;

	typedef logic [`DATA_W-1:0] regVal;

	typedef logic [`INSTR_W-1:0] instrWord;

	// Bit 32 carries the sign for extension to 64 bits
	typedef logic [`IMM_W-1:0] immVal;

	typedef logic [`PC_W-1:0] pcVal;

	typedef logic [`HALF_W-1:0] halfVal;

	// Operation field of the instruction word
	typedef enum logic [`OP_W-1:0] {
		opNop  = 4'd0,
		opAdd  = 4'd1,      // Rn = Rs + Rt
		opSub  = 4'd2,      // Rn = Rs - Rt
		opAnd  = 4'd3,
		opOr   = 4'd4,
		opXor  = 4'd5,
		opAddi = 4'd6,      // Rt replaced by the immediate
		opMuls = 4'd7       // Product goes to DLR and DHR
	} aluOp;

endpackage

// ==== source/opDecode.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module opDecode (
	input  logic             clock,
	input  logic             rst,
	input  logic             hold,
	input  logic             instrValid,
	input  corePkg::instrWord instr,
	input  logic             mulInFlight,     // MULS in EX1 or EX2
	input  logic             mulInEx3,        // MULS about to commit
	output corePkg::regId     idRs,
	output corePkg::regId     idRt,
	output corePkg::regId     idRn,
	output corePkg::immVal    imm,
	output corePkg::aluOp     op,
	output corePkg::pcVal     pc,
	output logic             issue,
	output logic             instrStall
);

	logic [5:0] fieldRn;
	logic [5:0] fieldRs;
	logic [5:0] fieldRt;
	logic       opWrites;
	logic       rnWritable;
	logic       readsMul;

	assign op      = corePkg::aluOp'(instr[`FLD_OP]);
	assign fieldRn = instr[`FLD_RN];
	assign fieldRs = instr[`FLD_RS];
	assign fieldRt = instr[`FLD_RT];

	assign idRs = {1'b0, fieldRs};
	assign idRt = (op == corePkg::opAddi) ? `GR_IMM : {1'b0, fieldRt};

	// Only ALU ops produce a result for Rn, never MULS or NOP
	assign opWrites = op inside {corePkg::opAdd, corePkg::opSub, corePkg::opAnd,
		corePkg::opOr, corePkg::opXor, corePkg::opAddi};

	// Of the specials only DLR, DHR and SP hold state
	assign rnWritable = !fieldRn[5] ||
		({1'b0, fieldRn} inside {`GR_DLR, `GR_DHR, `GR_SP});

	assign idRn = (opWrites && rnWritable) ? {1'b0, fieldRn} : `GR_ZZR;

	assign imm = {{(`IMM_W - `IMM_FLD_W){instr[`IMM_FLD_W-1]}}, instr[`FLD_IMM]};

	assign readsMul = (idRs == `GR_DLR) || (idRs == `GR_DHR) ||
		(idRt == `GR_DLR) || (idRt == `GR_DHR);

	// DLR and DHR are stale until the product commits after EX3
	assign instrStall = instrValid && readsMul && (mulInFlight || mulInEx3);

	assign issue = instrValid && !hold && !instrStall;

	// PC of the instruction now on instr
	always_ff @(posedge clock) begin
		if (rst) begin
			pc <= '0;
		end else if (issue) begin
			pc <= pc + `PC_STEP;
		end
	end

	// A pending MULS leaves EX3 within three unheld cycles
	assert property (@(posedge clock) disable iff (rst)
		(instrStall && !hold) ##1 (instrStall && !hold) ##1 (instrStall && !hold)
		|=> !instrStall)
		else $error("Interlock on DLR/DHR held for more than three cycles");

endmodule

// ==== source/regFileGpr.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module regFileGpr (
	input  logic          clock,
	input  logic          rst,
	input  logic          hold,
	input  corePkg::regId  idRs,
	input  corePkg::regId  idRt,
	output corePkg::regVal valRs,
	output corePkg::regVal valRt,
	input  corePkg::regId  idRn1,       // EX1 destination
	input  corePkg::regId  idRn2,       // EX2 destination
	input  corePkg::regId  idRn3,       // EX3 destination and write port
	input  corePkg::regVal valRn1,
	input  corePkg::regVal valRn2,
	input  corePkg::regVal valRn3,
	input  corePkg::pcVal  pc,
	input  corePkg::immVal imm,
	input  corePkg::regVal inDlr,
	input  corePkg::regVal inDhr,
	output corePkg::regVal outDlr,
	output corePkg::regVal outDhr
);

	corePkg::regVal gprArr [`GPR_COUNT];
	corePkg::regVal dlrReg;
	corePkg::regVal dhrReg;
	corePkg::regVal spReg;
	corePkg::regVal immExt;
	corePkg::regVal pcExt;

	assign immExt = {{(`DATA_W - `IMM_W){imm[`IMM_W-1]}}, imm};
	assign pcExt  = {{(`DATA_W - `PC_W){1'b0}}, pc};

	assign outDlr = dlrReg;
	assign outDhr = dhrReg;

	// Stored value of a source with the newest in-flight result on top
	function automatic corePkg::regVal readSource(input corePkg::regId id);
		corePkg::regVal val;
		logic noBypass;
		noBypass = 1'b0;
		if (!id[`GPR_IDX_W]) begin
			val = gprArr[id[`GPR_IDX_W-1:0]];
		end else begin
			case (id)
				`GR_DLR: val = dlrReg;
				`GR_DHR: val = dhrReg;
				`GR_SP:  val = spReg;
				`GR_PC:  val = pcExt;
				`GR_IMM: begin
					val      = immExt;
					noBypass = 1'b1;     // Constant, never a destination
				end
				`GR_ZZR: begin
					val      = '0;
					noBypass = 1'b1;     // Bubbles carry ZZR
				end
				default: val = '0;
			endcase
		end
		if (!noBypass) begin
			if (id == idRn3) begin
				val = valRn3;
			end
			if (id == idRn2) begin
				val = valRn2;
			end
			if (id == idRn1) begin
				val = valRn1;          // Youngest wins
			end
		end
		return val;
	endfunction

	always_comb begin
		valRs = readSource(idRs);
		valRt = readSource(idRt);
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < `GPR_COUNT; i++) begin
				gprArr[i] <= '0;
			end
			dlrReg <= '0;
			dhrReg <= '0;
			spReg  <= '0;
		end else if (!hold) begin
			if (!idRn3[`GPR_IDX_W]) begin
				gprArr[idRn3[`GPR_IDX_W-1:0]] <= valRn3;
			end
			if (idRn3 == `GR_SP) begin
				spReg <= valRn3;
			end
			// Side path carries the product or the current value back
			dlrReg <= (idRn3 == `GR_DLR) ? valRn3 : inDlr;
			dhrReg <= (idRn3 == `GR_DHR) ? valRn3 : inDhr;
		end
	end

	// Ids 36 to 61 have no register behind them in this slice
	assert property (@(posedge clock) disable iff (rst)
		(!hold && !$isunknown(idRs) && idRs[`GPR_IDX_W]) |->
		(idRs inside {`GR_DLR, `GR_DHR, `GR_SP, `GR_PC, `GR_IMM, `GR_ZZR}))
		else $error("Source Rs names an undefined special register");

endmodule

// ==== source/aluExecute.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module aluExecute (
	input  logic          clock,
	input  logic          rst,
	input  logic          hold,
	input  logic          issue,
	input  corePkg::aluOp  op,
	input  corePkg::regId  idRn,
	input  corePkg::regVal valRs,
	input  corePkg::regVal valRt,
	output corePkg::regId  idRn1,
	output corePkg::regId  idRn2,
	output corePkg::regVal valRn1,
	output corePkg::regVal valRn2,
	output logic          ex2Valid,
	output logic          mulValid,
	output logic          mulInFlight,
	output corePkg::regVal mulLo,
	output corePkg::regVal mulHi
);

	logic                 ex1Valid;
	corePkg::aluOp         ex1Op;
	corePkg::regVal        ex1A;
	corePkg::regVal        ex1B;
	logic signed [`DATA_W-1:0] product;
	corePkg::regVal        ex2Prod;

	always_ff @(posedge clock) begin
		if (rst) begin
			ex1Valid <= 1'b0;
			ex1Op    <= corePkg::opNop;
			idRn1    <= `GR_ZZR;
			ex2Valid <= 1'b0;
			mulValid <= 1'b0;
			idRn2    <= `GR_ZZR;
		end else if (!hold) begin
			ex1Valid <= issue;
			ex1Op    <= issue ? op : corePkg::opNop;
			idRn1    <= issue ? idRn : `GR_ZZR;     // Bubble when nothing issues
			ex2Valid <= ex1Valid;
			mulValid <= ex1Valid && (ex1Op == corePkg::opMuls);
			idRn2    <= idRn1;
		end
	end

	always_ff @(posedge clock) begin
		if (!hold) begin
			ex1A    <= valRs;
			ex1B    <= valRt;
			valRn2  <= valRn1;
			ex2Prod <= product;
		end
	end

	always_comb begin
		case (ex1Op)
			corePkg::opAdd, corePkg::opAddi: valRn1 = ex1A + ex1B;
			corePkg::opSub: valRn1 = ex1A - ex1B;
			corePkg::opAnd: valRn1 = ex1A & ex1B;
			corePkg::opOr:  valRn1 = ex1A | ex1B;
			corePkg::opXor: valRn1 = ex1A ^ ex1B;
			default:        valRn1 = '0;
		endcase
	end

	// Signed 32x32 with the full 64-bit product
	assign product = $signed(ex1A[`HALF_W-1:0]) * $signed(ex1B[`HALF_W-1:0]);

	assign mulLo = {{`HALF_W{ex2Prod[`HALF_W-1]}}, ex2Prod[`HALF_W-1:0]};
	assign mulHi = {{`HALF_W{ex2Prod[`DATA_W-1]}}, ex2Prod[`DATA_W-1:`HALF_W]};

	assign mulInFlight = (ex1Valid && (ex1Op == corePkg::opMuls)) || mulValid;

endmodule

// ==== source/resultStage.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module resultStage (
	input  logic          clock,
	input  logic          rst,
	input  logic          hold,
	input  logic          ex2Valid,
	input  logic          mulValid,
	input  corePkg::regId  idRn2,
	input  corePkg::regVal valRn2,
	input  corePkg::regVal mulLo,
	input  corePkg::regVal mulHi,
	input  corePkg::regVal outDlr,
	input  corePkg::regVal outDhr,
	output corePkg::regId  idRn3,
	output corePkg::regVal valRn3,
	output corePkg::regVal inDlr,
	output corePkg::regVal inDhr,
	output logic          mulInEx3,
	output logic          retireValid,
	output corePkg::regId  retireId,
	output corePkg::regVal retireValue
);

	corePkg::regVal ex3Hi;

	always_ff @(posedge clock) begin
		if (rst) begin
			retireValid <= 1'b0;
			mulInEx3    <= 1'b0;
			idRn3       <= `GR_ZZR;
		end else if (!hold) begin
			retireValid <= ex2Valid;
			mulInEx3    <= mulValid;
			idRn3       <= idRn2;
		end
	end

	// For MULS the slot value is the low half, as retired
	always_ff @(posedge clock) begin
		if (!hold) begin
			valRn3 <= mulValid ? mulLo : valRn2;
			ex3Hi  <= mulHi;
		end
	end

	assign retireId    = idRn3;
	assign retireValue = valRn3;

	// Product lands on the next edge, otherwise DLR/DHR recirculate
	assign inDlr = mulInEx3 ? valRn3 : outDlr;
	assign inDhr = mulInEx3 ? ex3Hi : outDhr;

	// Decode forces the MULS destination, so it must arrive here as ZZR
	assert property (@(posedge clock) disable iff (rst)
		(retireValid && mulInEx3) |-> (retireId == `GR_ZZR))
		else $error("MULS retired with a destination other than ZZR");

endmodule

// ==== source/coreTop.sv ====
`timescale 1ns/1ps

module coreTop (
	input  logic             clock,
	input  logic             rst,
	input  logic             hold,
	input  logic             instrValid,
	input  corePkg::instrWord instr,
	output logic             instrStall,
	output logic             retireValid,
	output corePkg::regId     retireId,
	output corePkg::regVal    retireValue
);

	corePkg::regId  idRs;
	corePkg::regId  idRt;
	corePkg::regId  idRn;
	corePkg::immVal imm;
	corePkg::aluOp  op;
	corePkg::pcVal  pc;
	logic          issue;
	logic          mulInFlight;
	logic          mulInEx3;
	corePkg::regVal valRs;
	corePkg::regVal valRt;
	corePkg::regId  idRn1;
	corePkg::regId  idRn2;
	corePkg::regId  idRn3;
	corePkg::regVal valRn1;
	corePkg::regVal valRn2;
	corePkg::regVal valRn3;
	logic          ex2Valid;
	logic          mulValid;
	corePkg::regVal mulLo;
	corePkg::regVal mulHi;
	corePkg::regVal inDlr;
	corePkg::regVal inDhr;
	corePkg::regVal outDlr;
	corePkg::regVal outDhr;

	opDecode opDecode_inst (.*);          // Fields, PC, interlock

	regFileGpr regFileGpr_inst (.*);      // Operands with bypass

	aluExecute aluExecute_inst (.*);      // EX1 and EX2

	resultStage resultStage_inst (.*);    // EX3 and retire

endmodule

// ==== test/coreModel.svh ====
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

corePkg::regVal archGpr [`GPR_COUNT];
corePkg::regVal archDlr;
corePkg::regVal archDhr;
corePkg::regVal archSp;
corePkg::pcVal  archPc;
corePkg::regId  expIdQ [$];                 // Expected retires in program order
corePkg::regVal expValQ [$];

function automatic corePkg::regVal immOf(input corePkg::instrWord w);
	return {{(`DATA_W - `IMM_FLD_W){w[`IMM_FLD_W-1]}}, w[`FLD_IMM]};
endfunction

function automatic corePkg::regVal archRead(input logic [5:0] fld, input corePkg::instrWord w);
	if (!fld[5]) begin
		return archGpr[fld[4:0]];
	end
	case ({1'b0, fld})
		`GR_DLR: return archDlr;
		`GR_DHR: return archDhr;
		`GR_SP:  return archSp;
		`GR_PC:  return {32'd0, archPc};       // Address of this instruction
		`GR_IMM: return immOf(w);
		default: return '0;
	endcase
endfunction

task automatic modelReset();
	for (int i = 0; i < `GPR_COUNT; i++) begin
		archGpr[i] = '0;
	end
	archDlr = '0;
	archDhr = '0;
	archSp  = '0;
	archPc  = '0;
	expIdQ.delete();
	expValQ.delete();
endtask

task automatic modelAccept(input corePkg::instrWord w);
	corePkg::aluOp opc;
	corePkg::regId dest;
	corePkg::regVal a;
	corePkg::regVal b;
	corePkg::regVal res;
	logic signed [`DATA_W-1:0] prod;
	opc  = corePkg::aluOp'(w[`FLD_OP]);
	dest = {1'b0, w[`FLD_RN]};
	a    = archRead(w[`FLD_RS], w);
	b    = (opc == corePkg::opAddi) ? immOf(w) : archRead(w[`FLD_RT], w);
	prod = $signed(a[31:0]) * $signed(b[31:0]);
	case (opc)
		corePkg::opAdd, corePkg::opAddi: res = a + b;
		corePkg::opSub:  res = a - b;
		corePkg::opAnd:  res = a & b;
		corePkg::opOr:   res = a | b;
		corePkg::opXor:  res = a ^ b;
		corePkg::opMuls: res = {{32{prod[31]}}, prod[31:0]};     // Low half
		default:         res = '0;
	endcase
	// Only GPRs, DLR, DHR and SP can take an ALU result
	if ((opc inside {corePkg::opNop, corePkg::opMuls}) ||
		(dest[5] && !(dest inside {`GR_DLR, `GR_DHR, `GR_SP}))) begin
		dest = `GR_ZZR;
	end
	if (opc == corePkg::opMuls) begin
		archDlr = res;
		archDhr = {{32{prod[63]}}, prod[63:32]};
	end else if (!dest[5]) begin
		archGpr[dest[4:0]] = res;
	end else if (dest == `GR_DLR) begin
		archDlr = res;
	end else if (dest == `GR_DHR) begin
		archDhr = res;
	end else if (dest == `GR_SP) begin
		archSp = res;
	end
	archPc = archPc + 32'd4;
	expIdQ.push_back(dest);
	expValQ.push_back(res);
endtask

`endif

// ==== test/coreTb.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module coreTb;

	localparam int chainLen  = 60;
	localparam int mulRounds = 4;
	localparam int holdLen   = 40;
	localparam int plannedInstr = 31 + chainLen + 18 + 5 + 2 + 3 * mulRounds + holdLen + 7;

	logic clock = 1'b0;
	logic rst;
	logic hold;
	logic instrValid;
	corePkg::instrWord instr;
	logic instrStall;
	logic retireValid;
	corePkg::regId retireId;
	corePkg::regVal retireValue;

	integer seed = 32'h2fd5;
	logic holdMode = 1'b0;              // Random hold pulses while set
	int stallCount = 0;
	logic headValid = 1'b0;             // Queue front as seen at the next edge
	corePkg::regId headId;
	corePkg::regVal headVal;

	`include "coreModel.svh"

	coreTop coreTop_inst (.*);

	always #5 clock = ~clock;

	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	always @(posedge clock) begin
		if (rst) begin
			modelReset();
		end else begin
			if (retireValid && !hold && expIdQ.size() > 0) begin
				void'(expIdQ.pop_front());
				void'(expValQ.pop_front());
			end
			if (instrValid && !hold && !instrStall) begin
				modelAccept(instr);
			end
			if (instrStall) begin
				stallCount++;
			end
		end
		headValid <= (expIdQ.size() > 0);
		headId    <= (expIdQ.size() > 0) ? expIdQ[0] : `GR_ZZR;
		headVal   <= (expValQ.size() > 0) ? expValQ[0] : '0;
	end

	assert property (@(posedge clock) $fell(rst) |-> (!retireValid && !instrStall))
		else stopWithFailure($sformatf("[ERROR] %0t: retireValid or instrStall high after reset",
			$time));
	assert property (@(posedge clock) disable iff (rst) (retireValid && !hold) |-> headValid)
		else stopWithFailure("A result retired while no accepted instruction was outstanding");
	assert property (@(posedge clock) disable iff (rst)
		(retireValid && !hold && headValid) |-> (retireId == headId))
		else stopWithFailure($sformatf("[ERROR] %0t: retireId %0d, expected %0d", $time,
			$sampled(retireId), $sampled(headId)));
	assert property (@(posedge clock) disable iff (rst)
		(retireValid && !hold && headValid) |-> (retireValue == headVal))
		else stopWithFailure($sformatf("[ERROR] %0t: retireValue %h, expected %h", $time,
			$sampled(retireValue), $sampled(headVal)));
	assert property (@(posedge clock) disable iff (rst)
		hold |=> ($stable(retireValid) && $stable(retireId) && $stable(retireValue)))
		else stopWithFailure($sformatf("[ERROR] %0t: retire outputs changed under hold", $time));

	function automatic corePkg::instrWord makeInstr(input corePkg::aluOp opc,
		input logic [5:0] rn, input logic [5:0] rs, input logic [5:0] rt, input logic [9:0] im);
		return {opc, rn, rs, rt, im};
	endfunction

	function automatic logic pickHold();
		logic [31:0] r;
		r = $random(seed);
		return holdMode && (r[1:0] == 2'd0);
	endfunction

	function automatic logic [5:0] pickSrc(input logic withMul);
		logic [31:0] r;
		r = $random(seed);
		if (withMul && r[7:5] == 3'd0) begin
			return r[8] ? 6'd33 : 6'd32;      // DHR or DLR
		end
		return {1'b0, r[4:0]};
	endfunction

	function automatic corePkg::instrWord randomInstr(input logic withMul);
		logic [31:0] r;
		logic [3:0] opc;
		r   = $random(seed);
		opc = 4'(r % (withMul ? 32'd7 : 32'd6)) + 4'd1;
		if (opc == 4'd7) begin
			return makeInstr(corePkg::opMuls, 6'd63, pickSrc(1'b0), pickSrc(1'b0), r[25:16]);
		end
		return makeInstr(corePkg::aluOp'(opc), {1'b0, r[14:10]}, pickSrc(withMul),
			pickSrc(withMul), r[25:16]);
	endfunction

	// Holds the instruction on instr until an edge accepts it
	task automatic sendInstr(input corePkg::instrWord w);
		logic accepted;
		instrValid <= 1'b1;
		instr      <= w;
		hold       <= pickHold();
		do begin
			@(posedge clock);
			accepted = !hold && !instrStall;
			if (!accepted) begin
				hold <= pickHold();
			end
		end while (!accepted);
	endtask

	initial begin
		#(plannedInstr * 20 + 2000);
		stopWithFailure("Timeout: the instructions did not all retire in time");
	end

	initial begin
		rst = 1'b1;
		hold = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		repeat (3) @(posedge clock);
		rst <= 1'b0;
		@(posedge clock);
		for (int i = 1; i < 32; i++) begin
			sendInstr(makeInstr(corePkg::opAddi, 6'(i), 6'd0, 6'd0, 10'($random(seed))));
		end
		repeat (chainLen) sendInstr(randomInstr(1'b0));
		for (int d = 1; d <= 4; d++) begin            // Rn1, Rn2, Rn3, then the array
			sendInstr(makeInstr(corePkg::opAddi, 6'd5, 6'd0, 6'd0, 10'd1));
			sendInstr(makeInstr(corePkg::opAddi, 6'd5, 6'd0, 6'd0, 10'(d * 37)));
			for (int f = 1; f < d; f++) begin
				sendInstr(makeInstr(corePkg::opAddi, 6'd20, 6'd0, 6'd0, 10'(f)));
			end
			sendInstr(makeInstr(corePkg::opAdd, 6'd6, 6'd5, 6'd5, 10'd0));
		end
		sendInstr(makeInstr(corePkg::opAddi, 6'd63, 6'd0, 6'd0, 10'd123));
		sendInstr(makeInstr(corePkg::opAdd, 6'd7, 6'd63, 6'd63, 10'd0));
		sendInstr(makeInstr(corePkg::opAddi, 6'd8, 6'd0, 6'd0, 10'h3fb));
		sendInstr(makeInstr(corePkg::opAddi, 6'd9, 6'd8, 6'd0, 10'h2d4));
		sendInstr(makeInstr(corePkg::opAdd, 6'd10, 6'd35, 6'd63, 10'd0));   // PC read
		sendInstr(makeInstr(corePkg::opAddi, 6'd1, 6'd0, 6'd0, 10'h2c9));
		sendInstr(makeInstr(corePkg::opAddi, 6'd2, 6'd0, 6'd0, 10'd457));
		for (int k = 0; k < mulRounds; k++) begin
			if (k == 0) begin
				sendInstr(makeInstr(corePkg::opMuls, 6'd63, 6'd1, 6'd2, 10'd0));
			end else begin
				sendInstr(makeInstr(corePkg::opMuls, 6'd63, pickSrc(1'b0), pickSrc(1'b0), 10'd0));
			end
			sendInstr(makeInstr(corePkg::opAdd, 6'(20 + k), 6'd32, 6'd63, 10'd0));
			sendInstr(makeInstr(corePkg::opAdd, 6'(24 + k), 6'd33, 6'd0, 10'd0));
		end
		holdMode = 1'b1;
		repeat (holdLen) sendInstr(randomInstr(1'b1));
		holdMode = 1'b0;
		sendInstr(makeInstr(corePkg::opAddi, 6'd34, 6'd0, 6'd0, 10'd99));
		sendInstr(makeInstr(corePkg::opAdd, 6'd13, 6'd34, 6'd63, 10'd0));   // SP via Rn1
		sendInstr(makeInstr(corePkg::opAdd, 6'd34, 6'd34, 6'd13, 10'd0));
		repeat (3) sendInstr(makeInstr(corePkg::opAddi, 6'd15, 6'd0, 6'd0, 10'd1));
		sendInstr(makeInstr(corePkg::opAdd, 6'd14, 6'd34, 6'd63, 10'd0));   // SP from storage
		instrValid <= 1'b0;
		hold       <= 1'b0;
		while (expIdQ.size() != 0) begin
			@(posedge clock);
		end
		repeat (4) @(posedge clock);
		if (stallCount == 0) begin
			stopWithFailure("A DLR/DHR read right after MULS never raised instrStall");
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

// ==== all.f ====
+incdir+source
+incdir+test
source/corePkg.sv
source/opDecode.sv
source/regFileGpr.sv
source/aluExecute.sv
source/resultStage.sv
source/coreTop.sv
test/coreTb.sv
